/* dv/tb_spam_system.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_spam_system import spam_pkg::*; ();

	localparam int CLK_PERIOD  = 40;
	localparam int RAND_REQS   = 200;
	localparam int TOTAL_CYC   = 20 + (RAND_REQS + 8) + 2 * 19 + 42 + 28 + 15;	// Sum of test lengths
	localparam int WATCHDOG_NS = TOTAL_CYC * CLK_PERIOD * 3 / 2;

	typedef struct packed {
		int                     due;	// Cycle the response shows on spami
		logic [SPAM_DATA_W-1:0] data;
		logic                   cons_wr;
		logic [7:0]             cons_byte;
	} exp_t;

	logic      cclk;
	logic      cclk_rst_cause_b;
	logic      corerst_btn;
	spam_req_t spamo;
	spam_rsp_t spami;
	cons_out_t cons_out;
	logic      sys_ready;

	int                     cyc = 0;
	logic                   chk_en;
	exp_t                   exp_q[$];	// Expected responses in issue order
	logic                   exp_ack;
	logic [SPAM_DATA_W-1:0] exp_data;
	logic                   exp_cons_valid;
	logic [7:0]             exp_cons_byte;
	logic [SPAM_DATA_W-1:0] cons_count;	// Model of the console byte count
	logic [SPAM_DATA_W-1:0] tw_val;	// Last counter load
	int                     tw_cyc;
	logic [SPAM_DATA_W-1:0] cmp_val;
	logic                   cmp_armed;
	logic                   flag_cleared;

	spam_system dut (
		.cclk             (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.corerst_btn      (corerst_btn),
		.spamo            (spamo),
		.spami            (spami),
		.cons_out         (cons_out),
		.sys_ready        (sys_ready)
	);

	initial begin
		cclk = 1'b0;
		forever #(CLK_PERIOD / 2) cclk = ~cclk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run did not finish in time, the watchdog stopped it");
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

	always @(posedge cclk) cyc <= cyc + 1;

	// Expected bus state for the cycle after this edge
	always @(posedge cclk) begin
		exp_t ent;
		#1;
		exp_ack        = 1'b0;
		exp_data       = '0;
		exp_cons_valid = 1'b0;
		if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
			ent            = exp_q.pop_front();
			exp_ack        = 1'b1;
			exp_data       = ent.data;
			exp_cons_valid = ent.cons_wr;
			exp_cons_byte  = ent.cons_byte;
		end
	end

	ack_matches: assert property (@(posedge cclk) disable iff (!chk_en) spami.ack == exp_ack)
		else report_mismatch("spami.ack", 32'($sampled(spami.ack)), 32'($sampled(exp_ack)));
	data_matches: assert property (@(posedge cclk) disable iff (!chk_en) spami.data == exp_data)
		else report_mismatch("spami.data", $sampled(spami.data), $sampled(exp_data));
	cons_valid_matches: assert property (@(posedge cclk) disable iff (!chk_en)
		cons_out.valid == exp_cons_valid)
		else report_mismatch("cons_out.valid", 32'($sampled(cons_out.valid)),
			32'($sampled(exp_cons_valid)));
	cons_byte_matches: assert property (@(posedge cclk) disable iff (!chk_en)
		cons_out.valid |-> cons_out.data == exp_cons_byte)
		else report_mismatch("cons_out.data", 32'($sampled(cons_out.data)),
			32'($sampled(exp_cons_byte)));
	quiet_in_reset: assert property (@(posedge cclk) disable iff (!chk_en)
		!sys_ready |-> !spami.ack)
		else report_failure("spami.ack went high while sys_ready was low");

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] want);
		$display("CHECK FAILED %s got 0x%08h expected 0x%08h", sig, got, want);
		$display("Finished with errors");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("ERROR %s", what);
		$display("Finished with errors");
		$fatal(1, "check failed");
	endtask

	// Timer read data as seen by a read issued this cycle
	function automatic logic [SPAM_DATA_W-1:0] timer_read(input logic [SPAM_ADDR_W-1:0] addr);
		logic [SPAM_DATA_W-1:0] cnt;
		logic [SPAM_DATA_W-1:0] result;
		cnt    = tw_val + 32'(cyc - tw_cyc);	// Value k cycles after the load
		result = '0;
		if (addr == TIMER_ADDR_COUNT) begin
			result = cnt;
		end else if (addr == TIMER_ADDR_COMPARE) begin
			result = cmp_val;
		end else if (addr == TIMER_ADDR_STATUS && cmp_armed && !flag_cleared &&
			$signed(cnt - cmp_val) > 1) begin	// Flag lands one edge after the counter holds C
			result       = 32'd1;
			flag_cleared = 1'b1;
		end
		return result;
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge cclk);
			#2;
		end
	endtask

	// One-cycle request plus its expected response
	task automatic send(input logic r_nw, input logic [SPAM_DID_W-1:0] did,
		input logic [SPAM_ADDR_W-1:0] addr, input logic [SPAM_DATA_W-1:0] data);
		exp_t ent;
		ent         = '0;
		ent.due     = cyc + 4;
		spamo.valid = 1'b1;
		spamo.r_nw  = r_nw;
		spamo.did   = did;
		spamo.addr  = addr;
		spamo.data  = data;
		if (did == DID_CONSOLE) begin
			if (addr == CONSOLE_ADDR_DATA && !r_nw) begin
				ent.cons_wr   = 1'b1;
				ent.cons_byte = data[7:0];
				cons_count    = cons_count + 32'd1;
			end else if (addr == CONSOLE_ADDR_DATA) begin
				ent.data = cons_count;
			end
			exp_q.push_back(ent);
		end else if (did == DID_TIMER) begin
			if (r_nw) begin
				ent.data = timer_read(addr);
			end else if (addr == TIMER_ADDR_COUNT) begin
				tw_val = data;
				tw_cyc = cyc;
			end else if (addr == TIMER_ADDR_COMPARE) begin
				cmp_val      = data;
				cmp_armed    = 1'b1;
				flag_cleared = 1'b0;
			end
			exp_q.push_back(ent);
		end
		@(posedge cclk);
		#2;
		spamo = '0;
	endtask

	task automatic drain_responses();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 8) begin
			idle(1);
			waited++;
		end
		if (exp_q.size() != 0) report_failure("responses still outstanding after the drain wait");
	endtask

	// sys_ready low for edges-1 edges, high after the last
	task automatic check_release(input int edges);
		for (int i = 1; i <= edges; i++) begin
			@(posedge cclk);
			#1;
			assert (sys_ready == (i == edges))
				else report_mismatch("sys_ready", 32'(sys_ready), 32'(i == edges));
		end
		#1;
	endtask

	task automatic press_button();
		logic fell;
		fell        = 1'b0;
		corerst_btn = 1'b1;
		for (int i = 0; i < BTN_SYNC_STAGES && !fell; i++) begin
			@(posedge cclk);
			#1;
			fell = !sys_ready;
		end
		assert (fell) else report_failure("sys_ready did not fall within 3 cycles of the press");
		#1;
		repeat (3) begin	// Console writes that must stay unanswered in reset
			spamo       = '0;
			spamo.valid = 1'b1;
			spamo.did   = DID_CONSOLE;
			spamo.addr  = CONSOLE_ADDR_DATA;
			spamo.data  = $urandom();
			@(posedge cclk);
			#2;
		end
		spamo        = '0;
		corerst_btn  = 1'b0;
		cons_count   = '0;	// Whole system restarts
		cmp_val      = '0;
		cmp_armed    = 1'b0;
		flag_cleared = 1'b0;
		check_release(BTN_SYNC_STAGES + RST_STRETCH_CYCLES);
	endtask

	initial begin
		int          kind;
		logic [31:0] w;
		void'($urandom(35));
		cclk_rst_cause_b = 1'b0;
		corerst_btn      = 1'b0;
		spamo            = '0;
		chk_en           = 1'b0;
		exp_ack          = 1'b0;
		exp_data         = '0;
		exp_cons_valid   = 1'b0;
		exp_cons_byte    = '0;
		cons_count       = '0;
		tw_val           = '0;
		tw_cyc           = 0;
		cmp_val          = '0;
		cmp_armed        = 1'b0;
		flag_cleared     = 1'b0;
		repeat (4) @(posedge cclk);
		#2;
		chk_en           = 1'b1;
		cclk_rst_cause_b = 1'b1;
		check_release(RST_STRETCH_CYCLES);

		repeat (RAND_REQS) begin	// Back-to-back mixed traffic
			kind = $urandom_range(0, 6);
			case (kind)
				0: send(1'b0, DID_CONSOLE, CONSOLE_ADDR_DATA, $urandom());
				1: send(1'b1, DID_CONSOLE, CONSOLE_ADDR_DATA, $urandom());
				2: send(1'b0, DID_CONSOLE, 8'($urandom_range(1, 255)), $urandom());
				3: send(1'b1, DID_TIMER, TIMER_ADDR_COMPARE, '0);
				4: send(1'b1, DID_TIMER, TIMER_ADDR_STATUS, '0);
				5: send(1'($urandom_range(0, 1)), 4'($urandom_range(3, 15)), 8'($urandom()),
					$urandom());	// Unknown device
				default: send(1'b1, DID_TIMER, 8'($urandom_range(3, 255)), '0);
			endcase
		end
		drain_responses();

		repeat (2) begin
			kind = $urandom_range(1, 10);
			w    = $urandom();
			send(1'b0, DID_TIMER, TIMER_ADDR_COUNT, w);
			idle(kind - 1);
			send(1'b1, DID_TIMER, TIMER_ADDR_COUNT, '0);
			drain_responses();
		end

		w = $urandom();
		send(1'b0, DID_TIMER, TIMER_ADDR_COUNT, w);
		send(1'b0, DID_TIMER, TIMER_ADDR_COMPARE, w + 32'd20);
		send(1'b1, DID_TIMER, TIMER_ADDR_STATUS, '0);	// Before the match
		idle(27);
		send(1'b1, DID_TIMER, TIMER_ADDR_STATUS, '0);
		send(1'b1, DID_TIMER, TIMER_ADDR_STATUS, '0);	// Cleared by the read before
		send(1'b1, DID_TIMER, TIMER_ADDR_COMPARE, '0);
		drain_responses();

		press_button();
		send(1'b1, DID_CONSOLE, CONSOLE_ADDR_DATA, '0);
		repeat (5) send(1'b0, DID_CONSOLE, CONSOLE_ADDR_DATA, $urandom());
		send(1'b1, DID_CONSOLE, CONSOLE_ADDR_DATA, '0);
		drain_responses();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the SPAM bus testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spam_system -Mdir "$BUILD_DIR" -o sim_spam -f verilog.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_spam" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -q "Finished with no errors" "$LOG"; then
	echo "Simulation did not complete"
	exit 1
fi
exit 0

/* verilog.f */
verilog/spam_pkg.sv
verilog/spam_reset_gen.sv
verilog/spam_decode.sv
verilog/spam_timer.sv
verilog/spam_console.sv
verilog/spam_result.sv
verilog/spam_system.sv
dv/tb_spam_system.sv

/* verilog/spam_console.sv */
`timescale 1ns/1ns
`default_nettype none

module spam_console import spam_pkg::*; (
	input  logic      cclk,
	input  logic      rst_b,
	input  dev_cmd_t  cmd,
	output spam_rsp_t rsp,
	output cons_out_t cons_out
);

	logic [SPAM_DATA_W-1:0] byte_count;	// Bytes written since reset
	cons_out_t              out_q;	// Byte taken at the execute edge
	logic                   wr_data;
	logic                   rd_count;

	assign wr_data  = cmd.strobe && !cmd.r_nw && (cmd.addr == CONSOLE_ADDR_DATA);
	assign rd_count = cmd.strobe && cmd.r_nw && (cmd.addr == CONSOLE_ADDR_DATA);

	// Writes to other addresses are acked but change nothing
	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			byte_count <= '0;
			out_q      <= '0;
		end else begin
			out_q.valid <= wr_data;
			if (wr_data) begin
				out_q.data <= cmd.data[7:0];	// Low byte only
				byte_count <= byte_count + 1'b1;
			end
		end
	end

	// One more stage so the byte leaves with the merged bus ack
	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			cons_out <= '0;
		end else begin
			cons_out <= out_q;
		end
	end

	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			rsp <= '0;
		end else begin
			rsp.ack  <= cmd.strobe;
			rsp.data <= rd_count ? byte_count : '0;	// Other reads give zero
		end
	end

endmodule

`default_nettype wire

/* verilog/spam_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module spam_decode import spam_pkg::*; (
	input  logic      cclk,
	input  logic      rst_b,
	input  spam_req_t spamo,
	output dev_cmd_t  timer_cmd,
	output dev_cmd_t  cons_cmd
);

	spam_req_t req_q;	// Request as taken off the bus
	logic      hit_timer;
	logic      hit_cons;

	// Builds the command handed to a matching device
	function automatic dev_cmd_t make_cmd(input spam_req_t req);
		dev_cmd_t cmd;
		cmd.strobe = 1'b1;
		cmd.r_nw   = req.r_nw;
		cmd.addr   = req.addr;
		cmd.data   = req.data;
		return cmd;
	endfunction

	// First stage captures the bus as is
	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			req_q <= '0;
		end else begin
			req_q <= spamo;
		end
	end

	// Unknown ids match nothing and fall away here
	assign hit_timer = req_q.valid && (req_q.did == DID_TIMER);
	assign hit_cons  = req_q.valid && (req_q.did == DID_CONSOLE);

	// Payload is held between strobes so the devices see stable fields
	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			timer_cmd <= '0;
			cons_cmd  <= '0;
		end else begin
			if (hit_timer) begin
				timer_cmd <= make_cmd(req_q);
			end else begin
				timer_cmd.strobe <= 1'b0;
			end
			if (hit_cons) begin
				cons_cmd <= make_cmd(req_q);
			end else begin
				cons_cmd.strobe <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/spam_pkg.sv */
`default_nettype none

package spam_pkg;

	// Bus field widths
	localparam int SPAM_DID_W  = 4;
	localparam int SPAM_ADDR_W = 8;
	localparam int SPAM_DATA_W = 32;

	// Device ids decoded from the request
	localparam logic [SPAM_DID_W-1:0] DID_CONSOLE = 4'd1;
	localparam logic [SPAM_DID_W-1:0] DID_TIMER   = 4'd2;

	// Timer register map
	localparam logic [SPAM_ADDR_W-1:0] TIMER_ADDR_COUNT   = 8'd0;
	localparam logic [SPAM_ADDR_W-1:0] TIMER_ADDR_COMPARE = 8'd1;
	localparam logic [SPAM_ADDR_W-1:0] TIMER_ADDR_STATUS  = 8'd2;

	// Console register map
	localparam logic [SPAM_ADDR_W-1:0] CONSOLE_ADDR_DATA = 8'd0;

	// Reset sequencing
	localparam int RST_STRETCH_CYCLES = 16;
	localparam int BTN_SYNC_STAGES    = 3;

	typedef struct packed {
		logic                   valid;	// One-cycle request strobe
		logic                   r_nw;	// High for read
		logic [SPAM_DID_W-1:0]  did;
		logic [SPAM_ADDR_W-1:0] addr;
		logic [SPAM_DATA_W-1:0] data;
	} spam_req_t;

	typedef struct packed {
		logic                   ack;	// Zero when idle, merged by OR
		logic [SPAM_DATA_W-1:0] data;
	} spam_rsp_t;

	typedef struct packed {
		logic                   strobe;	// Request for this device only
		logic                   r_nw;
		logic [SPAM_ADDR_W-1:0] addr;
		logic [SPAM_DATA_W-1:0] data;
	} dev_cmd_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;	// Character written by the core
	} cons_out_t;

endpackage

`default_nettype wire

/* verilog/spam_reset_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module spam_reset_gen import spam_pkg::*; (
	input  logic cclk,
	input  logic cclk_rst_cause_b,
	input  logic corerst_btn,
	output logic rst_b
);

	logic [BTN_SYNC_STAGES-1:0]    btn_sync;	// Button synchronizer chain
	logic [RST_STRETCH_CYCLES-1:0] stretch;	// Ones walk in after release
	logic                          btn_pressed;
	logic                          clr_b;	// Combined asynchronous clear

	// The button is asynchronous to cclk
	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			btn_sync <= '0;
		end else begin
			btn_sync <= {btn_sync[BTN_SYNC_STAGES-2:0], corerst_btn};
		end
	end

	assign btn_pressed = btn_sync[BTN_SYNC_STAGES-1];
	assign clr_b       = cclk_rst_cause_b & ~btn_pressed;

	// Assert at once, release only after the full stretch
	always_ff @(posedge cclk or negedge clr_b) begin
		if (!clr_b) begin
			stretch <= '0;
		end else begin
			stretch <= {stretch[RST_STRETCH_CYCLES-2:0], 1'b1};
		end
	end

	assign rst_b = stretch[RST_STRETCH_CYCLES-1];	// Last stage is the reset

endmodule

`default_nettype wire

/* verilog/spam_result.sv */
`timescale 1ns/1ns
`default_nettype none

module spam_result import spam_pkg::*; (
	input  logic      cclk,
	input  logic      rst_b,
	input  spam_rsp_t timer_rsp,
	input  spam_rsp_t cons_rsp,
	output spam_rsp_t spami
);

	spam_rsp_t merged;

	// Idle devices drive zero, so OR is enough to merge
	always_comb begin
		merged.ack  = timer_rsp.ack | cons_rsp.ack;
		merged.data = timer_rsp.data | cons_rsp.data;
	end

	// Single timing point for everything returned to the core
	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			spami <= '0;
		end else begin
			spami <= merged;
		end
	end

endmodule

`default_nettype wire

/* verilog/spam_system.sv */
`timescale 1ns/1ns
`default_nettype none

module spam_system import spam_pkg::*; (
	input  logic      cclk,
	input  logic      cclk_rst_cause_b,
	input  logic      corerst_btn,
	input  spam_req_t spamo,
	output spam_rsp_t spami,
	output cons_out_t cons_out,
	output logic      sys_ready
);

	logic      rst_b;	// Internal reset after sync and stretch
	dev_cmd_t  timer_cmd;
	dev_cmd_t  cons_cmd;
	spam_rsp_t timer_rsp;
	spam_rsp_t cons_rsp;

	assign sys_ready = rst_b;

	spam_reset_gen u_reset_gen (
		.cclk             (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.corerst_btn      (corerst_btn),
		.rst_b            (rst_b)
	);

	spam_decode u_decode (
		.cclk      (cclk),
		.rst_b     (rst_b),
		.spamo     (spamo),
		.timer_cmd (timer_cmd),
		.cons_cmd  (cons_cmd)
	);

	spam_timer u_timer (
		.cclk  (cclk),
		.rst_b (rst_b),
		.cmd   (timer_cmd),
		.rsp   (timer_rsp)
	);

	spam_console u_console (
		.cclk     (cclk),
		.rst_b    (rst_b),
		.cmd      (cons_cmd),
		.rsp      (cons_rsp),
		.cons_out (cons_out)
	);

	spam_result u_result (
		.cclk      (cclk),
		.rst_b     (rst_b),
		.timer_rsp (timer_rsp),
		.cons_rsp  (cons_rsp),
		.spami     (spami)
	);

endmodule

`default_nettype wire

/* verilog/spam_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module spam_timer import spam_pkg::*; (
	input  logic      cclk,
	input  logic      rst_b,
	input  dev_cmd_t  cmd,
	output spam_rsp_t rsp
);

	logic [SPAM_DATA_W-1:0] count;
	logic [SPAM_DATA_W-1:0] count_next;	// Value the counter takes this edge
	logic [SPAM_DATA_W-1:0] compare;
	logic                   armed;	// Set by the first compare write
	logic                   match_flag;	// Sticky until a status read
	logic                   wr;
	logic                   rd;
	logic                   wr_count;
	logic                   wr_compare;
	logic                   rd_status;
	logic [SPAM_DATA_W-1:0] rd_data;

	assign wr = cmd.strobe && !cmd.r_nw;
	assign rd = cmd.strobe && cmd.r_nw;

	assign wr_count   = wr && (cmd.addr == TIMER_ADDR_COUNT);
	assign wr_compare = wr && (cmd.addr == TIMER_ADDR_COMPARE);
	assign rd_status  = rd && (cmd.addr == TIMER_ADDR_STATUS);

	// A load replaces the increment for that cycle
	assign count_next = wr_count ? cmd.data : count + 1'b1;

	always_comb begin
		case (cmd.addr)
			TIMER_ADDR_COUNT:   rd_data = count_next;
			TIMER_ADDR_COMPARE: rd_data = compare;
			TIMER_ADDR_STATUS:  rd_data = {{(SPAM_DATA_W-1){1'b0}}, match_flag};
			default:            rd_data = '0;
		endcase
	end

	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			count      <= '0;
			compare    <= '0;
			armed      <= 1'b0;
			match_flag <= 1'b0;
		end else begin
			count <= count_next;
			if (wr_compare) begin
				compare <= cmd.data;
				armed   <= 1'b1;
			end
			// A fresh match beats the clear so no event is lost
			if (armed && (count == compare)) begin
				match_flag <= 1'b1;
			end else if (rd_status) begin
				match_flag <= 1'b0;
			end
		end
	end

	// Every strobe is acked, writes with zero data
	always_ff @(posedge cclk or negedge rst_b) begin
		if (!rst_b) begin
			rsp <= '0;
		end else begin
			rsp.ack  <= cmd.strobe;
			rsp.data <= rd ? rd_data : '0;
		end
	end

endmodule

`default_nettype wire
